/* Makefile */
# Verilator build and run of the CPU testbench

all: run

obj_dir/VtbCpu: list.f cpuPkg.sv pipeReg.sv fetchUnit.sv decodeUnit.sv executeUnit.sv \
    memoryUnit.sv hazardUnit.sv hostPort.sv cpuTop.sv tbCpu.sv
	verilator --binary -j 0 --top-module tbCpu -f list.f -Mdir obj_dir

run: obj_dir/VtbCpu
	./obj_dir/VtbCpu | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* cpuPkg.sv */
// CPU shared types
package cpuPkg;

    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int OPC_W     = 4;
    localparam int IMM_W     = 6;

    typedef logic [WORD_W-1:0]    wordT;
    typedef logic [REG_IDX_W-1:0] regIdxT;

    typedef enum logic [OPC_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_XOR  = 4'd3,
        OP_ADDI = 4'd4,
        OP_LD   = 4'd5,
        OP_ST   = 4'd6,
        OP_BEQZ = 4'd7,
        OP_NOP  = 4'd14,
        OP_HALT = 4'd15
    } opcodeT;

    // Fetch to decode
    typedef struct packed {
        wordT instr;
        wordT incPc;
    } fdPayloadT;

    // Decode to execute
    typedef struct packed {
        opcodeT opcode;
        regIdxT rsIdx;
        regIdxT rtIdx;
        regIdxT rdIdx;
        wordT   rsVal;
        wordT   rtVal;
        wordT   imm;
        wordT   incPc;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   isBranch;
        logic   isHalt;
    } dePayloadT;

    // Execute to memory
    typedef struct packed {
        wordT   result;
        wordT   storeData;
        regIdxT rdIdx;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   isHalt;
    } emPayloadT;

    // Memory to writeback
    typedef struct packed {
        wordT   result;
        wordT   loadData;
        regIdxT rdIdx;
        logic   regWrite;
        logic   memToReg;
        logic   isHalt;
    } mwPayloadT;

endpackage

/* cpuTop.sv */
// Five-stage CPU top level
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic clk,
    input  logic reset,
    input  logic run,
    input  logic hostReq,
    input  logic hostWrite,
    input  logic hostImem,
    input  wordT hostAddr,
    input  wordT hostWrData,
    output logic hostAck,
    output wordT hostRdData,
    output logic halted,
    output logic err
);

    wordT      fInstr;
    wordT      fIncPc;
    wordT      wbData;
    wordT      branchTarget;
    wordT      hostRdWord;
    fdPayloadT fdIn;
    fdPayloadT fdOut;
    dePayloadT deIn;
    dePayloadT deOut;
    emPayloadT emIn;
    emPayloadT emOut;
    mwPayloadT mwIn;
    mwPayloadT mwOut;
    regIdxT    rsIdx;
    regIdxT    rtIdx;
    logic      fdValid;
    logic      deValid;
    logic      emValid;
    logic      mwValid;
    logic      usesRt;
    logic      decValid;
    logic      branchTaken;
    logic      illegal;
    logic      stall;
    logic      flush;
    logic      advance;
    logic      coreActive;
    logic      imemWe;
    logic      dmemWe;
    logic [1:0] fwdA;
    logic [1:0] fwdB;
    logic [$clog2(IMEM_DEPTH)-1:0] imemHostAddr;
    logic [$clog2(DMEM_DEPTH)-1:0] dmemHostAddr;

    assign coreActive = run & ~halted;
    assign fdIn       = '{instr: fInstr, incPc: fIncPc};

    fetchUnit #(.IMEM_DEPTH(IMEM_DEPTH)) fetch (
        .clk(clk), .reset(reset), .advance(advance),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .imemWe(imemWe), .hostAddr(imemHostAddr), .hostWrData(hostWrData),
        .instr(fInstr), .incPc(fIncPc)
    );

    pipeReg #(.payloadT(fdPayloadT)) fdReg (
        .clk(clk), .reset(reset), .enable(advance), .flush(flush),
        .dIn(fdIn), .validIn(1'b1), .dOut(fdOut), .validOut(fdValid)
    );

    decodeUnit decode (
        .clk(clk), .reset(reset), .fd(fdOut), .fdValid(fdValid),
        .mw(mwOut), .mwValid(mwValid), .de(deIn), .rsIdx(rsIdx), .rtIdx(rtIdx),
        .usesRt(usesRt), .decValid(decValid), .wbData(wbData)
    );

    // Load-use stall leaves a bubble in execute
    pipeReg #(.payloadT(dePayloadT)) deReg (
        .clk(clk), .reset(reset), .enable(coreActive), .flush(flush | stall),
        .dIn(deIn), .validIn(decValid), .dOut(deOut), .validOut(deValid)
    );

    executeUnit execute (
        .de(deOut), .deValid(deValid), .fwdA(fwdA), .fwdB(fwdB),
        .emResult(emOut.result), .wbData(wbData), .em(emIn),
        .branchTaken(branchTaken), .branchTarget(branchTarget), .illegal(illegal)
    );

    pipeReg #(.payloadT(emPayloadT)) emReg (
        .clk(clk), .reset(reset), .enable(coreActive), .flush(1'b0),
        .dIn(emIn), .validIn(deValid), .dOut(emOut), .validOut(emValid)
    );

    memoryUnit #(.DMEM_DEPTH(DMEM_DEPTH)) memory (
        .clk(clk), .em(emOut), .emValid(emValid & coreActive),
        .dmemWe(dmemWe), .hostAddr(dmemHostAddr), .hostWrData(hostWrData),
        .mw(mwIn), .hostRdWord(hostRdWord)
    );

    pipeReg #(.payloadT(mwPayloadT)) mwReg (
        .clk(clk), .reset(reset), .enable(coreActive), .flush(1'b0),
        .dIn(mwIn), .validIn(emValid), .dOut(mwOut), .validOut(mwValid)
    );

    hazardUnit hazard (
        .clk(clk), .reset(reset),
        .deRs(deOut.rsIdx), .deRt(deOut.rtIdx), .deRd(deOut.rdIdx),
        .deMemRead(deValid & deOut.memRead),
        .rsIdx(rsIdx), .rtIdx(rtIdx), .usesRt(usesRt), .decValid(decValid),
        .emRd(emOut.rdIdx), .emRegWrite(emValid & emOut.regWrite),
        .mwRd(mwOut.rdIdx), .mwRegWrite(mwValid & mwOut.regWrite),
        .branchTaken(branchTaken), .exHalt(deValid & emIn.isHalt),
        .illegal(illegal), .mwHalt(mwValid & mwOut.isHalt), .coreActive(coreActive),
        .stall(stall), .flush(flush), .fwdA(fwdA), .fwdB(fwdB),
        .advance(advance), .halted(halted), .err(err)
    );

    hostPort #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) host (
        .clk(clk), .reset(reset), .coreStopped(~coreActive),
        .hostReq(hostReq), .hostWrite(hostWrite), .hostImem(hostImem),
        .hostAddr(hostAddr), .hostRdWord(hostRdWord),
        .hostAck(hostAck), .hostRdData(hostRdData),
        .imemWe(imemWe), .dmemWe(dmemWe),
        .imemHostAddr(imemHostAddr), .dmemHostAddr(dmemHostAddr)
    );

endmodule

/* decodeUnit.sv */
// Decode and register file
`timescale 1ns/1ps

module decodeUnit import cpuPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  fdPayloadT fd,
    input  logic      fdValid,
    input  mwPayloadT mw,
    input  logic      mwValid,
    output dePayloadT de,
    output regIdxT    rsIdx,
    output regIdxT    rtIdx,
    output logic      usesRt,
    output logic      decValid,
    output wordT      wbData
);

    wordT   regFile [2**REG_IDX_W];
    opcodeT opcode;
    logic   regWe;

    assign opcode = opcodeT'(fd.instr[15:12]);
    assign rsIdx  = fd.instr[8:6];
    // ST reads its data register from the rd field
    assign rtIdx  = (opcode == OP_ST) ? fd.instr[11:9] : fd.instr[5:3];
    assign usesRt = (opcode == OP_ADD) || (opcode == OP_SUB) || (opcode == OP_AND) ||
                    (opcode == OP_XOR) || (opcode == OP_ST);
    assign decValid = fdValid;

    // Writeback select
    assign regWe  = mwValid & mw.regWrite;
    assign wbData = mw.memToReg ? mw.loadData : mw.result;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_IDX_W; i++) begin
                regFile[i] <= '0;
            end
        end else if (regWe) begin
            regFile[mw.rdIdx] <= wbData;
        end
    end

    always_comb begin
        de        = '0;
        de.opcode = opcode;
        de.rsIdx  = rsIdx;
        de.rtIdx  = rtIdx;
        de.rdIdx  = fd.instr[11:9];
        // Write-first bypass of the same-cycle writeback
        de.rsVal  = (regWe && mw.rdIdx == rsIdx) ? wbData : regFile[rsIdx];
        de.rtVal  = (regWe && mw.rdIdx == rtIdx) ? wbData : regFile[rtIdx];
        de.imm    = {{(WORD_W-IMM_W){fd.instr[IMM_W-1]}}, fd.instr[IMM_W-1:0]};
        de.incPc  = fd.incPc;
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI: begin
                de.regWrite = 1'b1;
            end
            OP_LD: begin
                de.regWrite = 1'b1;
                de.memRead  = 1'b1;
            end
            OP_ST:   de.memWrite = 1'b1;
            OP_BEQZ: de.isBranch = 1'b1;
            OP_HALT: de.isHalt   = 1'b1;
            default: ;
        endcase
    end

endmodule

/* executeUnit.sv */
// Execute stage
`timescale 1ns/1ps

module executeUnit import cpuPkg::*; (
    input  dePayloadT  de,
    input  logic       deValid,
    input  logic [1:0] fwdA,
    input  logic [1:0] fwdB,
    input  wordT       emResult,
    input  wordT       wbData,
    output emPayloadT  em,
    output logic       branchTaken,
    output wordT       branchTarget,
    output logic       illegal
);

    wordT opA;
    wordT opB;
    wordT aluOut;
    logic legal;

    // Select code 10 takes EX/MEM and 01 takes MEM/WB
    always_comb begin
        case (fwdA)
            2'b10:   opA = emResult;
            2'b01:   opA = wbData;
            default: opA = de.rsVal;
        endcase
        case (fwdB)
            2'b10:   opB = emResult;
            2'b01:   opB = wbData;
            default: opB = de.rtVal;
        endcase
    end

    always_comb begin
        legal  = 1'b1;
        aluOut = '0;
        case (de.opcode)
            OP_ADD:                aluOut = opA + opB;
            OP_SUB:                aluOut = opA - opB;
            OP_AND:                aluOut = opA & opB;
            OP_XOR:                aluOut = opA ^ opB;
            OP_ADDI, OP_LD, OP_ST: aluOut = opA + de.imm;
            OP_BEQZ, OP_NOP, OP_HALT: aluOut = '0;
            default:               legal = 1'b0;
        endcase
    end

    assign illegal      = deValid & ~legal;
    assign branchTaken  = deValid & de.isBranch & (opA == '0);
    assign branchTarget = de.incPc + de.imm;

    always_comb begin
        em.result    = aluOut;
        em.storeData = opB;
        em.rdIdx     = de.rdIdx;
        em.regWrite  = de.regWrite;
        em.memRead   = de.memRead;
        em.memWrite  = de.memWrite;
        // Bad opcode stops the core like HALT
        em.isHalt    = de.isHalt | ~legal;
    end

endmodule

/* fetchUnit.sv */
// Instruction fetch
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          advance,
    input  logic                          branchTaken,
    input  wordT                          branchTarget,
    input  logic                          imemWe,
    input  logic [$clog2(IMEM_DEPTH)-1:0] hostAddr,
    input  wordT                          hostWrData,
    output wordT                          instr,
    output wordT                          incPc
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    wordT pc;
    wordT imem [IMEM_DEPTH];

    assign incPc = pc + 16'd1;
    assign instr = imem[pc[IMEM_AW-1:0]];

    // Branch target wins over sequential fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (advance) begin
            pc <= branchTaken ? branchTarget : incPc;
        end
    end

    // Program load from the host
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[hostAddr] <= hostWrData;
        end
    end

endmodule

/* hazardUnit.sv */
// Hazard and core status control
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  regIdxT     deRs,
    input  regIdxT     deRt,
    input  regIdxT     deRd,
    input  logic       deMemRead,
    input  regIdxT     rsIdx,
    input  regIdxT     rtIdx,
    input  logic       usesRt,
    input  logic       decValid,
    input  regIdxT     emRd,
    input  logic       emRegWrite,
    input  regIdxT     mwRd,
    input  logic       mwRegWrite,
    input  logic       branchTaken,
    input  logic       exHalt,
    input  logic       illegal,
    input  logic       mwHalt,
    input  logic       coreActive,
    output logic       stall,
    output logic       flush,
    output logic [1:0] fwdA,
    output logic [1:0] fwdB,
    output logic       advance,
    output logic       halted,
    output logic       err
);

    logic halting;

    // Load in execute feeding the instruction in decode
    assign stall = deMemRead & decValid &
                   ((deRd == rsIdx) | (usesRt & (deRd == rtIdx)));

    assign advance = coreActive & ~stall;

    // Squash younger work on a taken branch and behind a halt
    assign flush = branchTaken | exHalt | halting;

    assign fwdA = (emRegWrite && emRd == deRs) ? 2'b10 :
                  (mwRegWrite && mwRd == deRs) ? 2'b01 : 2'b00;
    assign fwdB = (emRegWrite && emRd == deRt) ? 2'b10 :
                  (mwRegWrite && mwRd == deRt) ? 2'b01 : 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            halting <= 1'b0;
            halted  <= 1'b0;
            err     <= 1'b0;
        end else if (coreActive) begin
            if (exHalt) begin
                halting <= 1'b1;
            end
            if (mwHalt) begin
                halted <= 1'b1;
            end
            if (illegal) begin
                err <= 1'b1;
            end
        end
    end

endmodule

/* hostPort.sv */
// Host memory access port
`timescale 1ns/1ps

module hostPort import cpuPkg::*; #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          coreStopped,
    input  logic                          hostReq,
    input  logic                          hostWrite,
    input  logic                          hostImem,
    input  wordT                          hostAddr,
    input  wordT                          hostRdWord,
    output logic                          hostAck,
    output wordT                          hostRdData,
    output logic                          imemWe,
    output logic                          dmemWe,
    output logic [$clog2(IMEM_DEPTH)-1:0] imemHostAddr,
    output logic [$clog2(DMEM_DEPTH)-1:0] dmemHostAddr
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    typedef enum logic [1:0] {
        HP_IDLE,
        HP_ACCESS,
        HP_ACK
    } hpStateT;

    hpStateT state;
    logic    accept;
    logic    reqWrite;
    logic    reqImem;

    assign accept = (state == HP_IDLE) & hostReq & coreStopped;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= HP_IDLE;
        end else begin
            case (state)
                HP_IDLE:   state <= accept ? HP_ACCESS : HP_IDLE;
                HP_ACCESS: state <= HP_ACK;
                HP_ACK:    state <= hostReq ? HP_ACK : HP_IDLE;
                default:   state <= HP_IDLE;
            endcase
        end
    end

    // Request fields captured once per handshake
    always_ff @(posedge clk) begin
        if (accept) begin
            reqWrite     <= hostWrite;
            reqImem      <= hostImem;
            imemHostAddr <= hostAddr[IMEM_AW-1:0];
            dmemHostAddr <= hostAddr[DMEM_AW-1:0];
        end
        if (state == HP_ACCESS && !reqWrite) begin
            hostRdData <= hostRdWord;
        end
    end

    assign imemWe  = (state == HP_ACCESS) & reqWrite & reqImem;
    assign dmemWe  = (state == HP_ACCESS) & reqWrite & ~reqImem;
    assign hostAck = (state == HP_ACK);

endmodule

/* list.f */
cpuPkg.sv
pipeReg.sv
fetchUnit.sv
decodeUnit.sv
executeUnit.sv
memoryUnit.sv
hazardUnit.sv
hostPort.sv
cpuTop.sv
tbCpu.sv

/* memoryUnit.sv */
// Data memory stage
`timescale 1ns/1ps

module memoryUnit import cpuPkg::*; #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  emPayloadT                     em,
    input  logic                          emValid,
    input  logic                          dmemWe,
    input  logic [$clog2(DMEM_DEPTH)-1:0] hostAddr,
    input  wordT                          hostWrData,
    output mwPayloadT                     mw,
    output wordT                          hostRdWord
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    wordT                dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0]  coreAddr;

    assign coreAddr = em.result[DMEM_AW-1:0];

    // Host writes only while the pipeline is frozen
    always_ff @(posedge clk) begin
        if (dmemWe) begin
            dmem[hostAddr] <= hostWrData;
        end else if (emValid && em.memWrite) begin
            dmem[coreAddr] <= em.storeData;
        end
    end

    assign hostRdWord = dmem[hostAddr];

    always_comb begin
        mw.result   = em.result;
        mw.loadData = dmem[coreAddr];
        mw.rdIdx    = em.rdIdx;
        mw.regWrite = em.regWrite;
        mw.memToReg = em.memRead;
        mw.isHalt   = em.isHalt;
    end

endmodule

/* pipeReg.sv */
// Pipeline stage register
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    enable,
    input  logic    flush,
    input  payloadT dIn,
    input  logic    validIn,
    output payloadT dOut,
    output logic    validOut
);

    // A flush only lands on a cycle the stage moves
    always_ff @(posedge clk) begin
        if (reset) begin
            validOut <= 1'b0;
        end else if (enable) begin
            validOut <= validIn & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            dOut <= dIn;
        end
    end

endmodule

/* tbCpu.sv */
// CPU pipeline testbench
`timescale 1ns/1ps

module tbCpu import cpuPkg::*; ();

    localparam int TIMEOUT = 2000;

    logic clk;
    logic reset;
    logic run;
    logic hostReq;
    logic hostWrite;
    logic hostImem;
    wordT hostAddr;
    wordT hostWrData;
    logic hostAck;
    wordT hostRdData;
    logic halted;
    logic err;

    logic [31:0] lfsrState;
    wordT        progWords [$];
    int          checkCount;
    int          errorCount;
    int          testErrors;

    cpuTop #(.IMEM_DEPTH(256), .DMEM_DEPTH(256)) i_dut (
        .clk(clk), .reset(reset), .run(run),
        .hostReq(hostReq), .hostWrite(hostWrite), .hostImem(hostImem),
        .hostAddr(hostAddr), .hostWrData(hostWrData),
        .hostAck(hostAck), .hostRdData(hostRdData), .halted(halted), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic randomWord(output wordT w);
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsrState = lfsrStep(lfsrState);
            w = {w[14:0], lfsrState[0]};
        end
    endtask

    function automatic wordT regInstr(input opcodeT op, input regIdxT rd, input regIdxT rs,
                                      input regIdxT rt);
        return {op, rd, rs, rt, 3'b000};
    endfunction

    function automatic wordT immInstr(input opcodeT op, input regIdxT rd, input regIdxT rs,
                                      input int imm);
        return {op, rd, rs, imm[5:0]};
    endfunction

    task automatic check(input string what, input wordT got, input wordT expected);
        checkCount++;
        if (got !== expected) begin
            $display("Error at %0d ns: %s read %h, expected %h", $time, what, got, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout at %0d ns: the %s never happened", $time, what);
        errorCount++;
        testErrors++;
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failing checks", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic restartCore();
        @(negedge clk);
        reset = 1'b1;
        run   = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic waitAck(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (hostAck !== level && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (hostAck !== level) begin
            reportTimeout(what);
        end
    endtask

    task automatic hostWriteWord(input logic toImem, input wordT addr, input wordT data);
        @(negedge clk);
        hostReq    = 1'b1;
        hostWrite  = 1'b1;
        hostImem   = toImem;
        hostAddr   = addr;
        hostWrData = data;
        waitAck(1'b1, "host write acknowledge");
        hostReq = 1'b0;
        waitAck(1'b0, "host acknowledge release");
    endtask

    task automatic hostReadWord(input wordT addr, output wordT data);
        @(negedge clk);
        hostReq   = 1'b1;
        hostWrite = 1'b0;
        hostImem  = 1'b0;
        hostAddr  = addr;
        waitAck(1'b1, "host read acknowledge");
        data    = hostRdData;
        hostReq = 1'b0;
        waitAck(1'b0, "host acknowledge release");
    endtask

    task automatic loadProgram();
        foreach (progWords[i]) begin
            hostWriteWord(1'b1, 16'(i), progWords[i]);
        end
    endtask

    task automatic runUntilHalt();
        int cycles;
        cycles = 0;
        @(negedge clk);
        run = 1'b1;
        while (!halted && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            reportTimeout("core halt");
        end
    endtask

    task automatic resetAndHostAccess();
        wordT written [8];
        wordT got;
        restartCore();
        check("halted after reset", 16'(halted), 16'd0);
        check("err after reset", 16'(err), 16'd0);
        check("hostAck after reset", 16'(hostAck), 16'd0);
        for (int i = 0; i < 8; i++) begin
            randomWord(written[i]);
            hostWriteWord(1'b0, 16'(32 + i), written[i]);
        end
        for (int i = 0; i < 8; i++) begin
            hostReadWord(16'(32 + i), got);
            check("data memory readback", got, written[i]);
        end
        finishTest("reset and host access");
    endtask

    task automatic aluForwardChain();
        wordT a;
        wordT b;
        wordT r3;
        wordT r4;
        wordT r5;
        wordT r6;
        wordT r7;
        wordT got;
        restartCore();
        randomWord(a);
        randomWord(b);
        hostWriteWord(1'b0, 16'd0, a);
        hostWriteWord(1'b0, 16'd1, b);
        // Every ALU op uses the result of the one before it
        progWords.delete();
        progWords.push_back(immInstr(OP_LD, 3'd1, 3'd0, 0));
        progWords.push_back(immInstr(OP_LD, 3'd2, 3'd0, 1));
        progWords.push_back(immInstr(OP_ADDI, 3'd3, 3'd1, -7));
        progWords.push_back(regInstr(OP_ADD, 3'd4, 3'd3, 3'd2));
        progWords.push_back(regInstr(OP_SUB, 3'd5, 3'd4, 3'd1));
        progWords.push_back(regInstr(OP_AND, 3'd6, 3'd5, 3'd4));
        progWords.push_back(regInstr(OP_XOR, 3'd7, 3'd6, 3'd3));
        progWords.push_back(immInstr(OP_ST, 3'd7, 3'd0, 12));
        progWords.push_back(immInstr(OP_ST, 3'd3, 3'd0, 8));
        progWords.push_back(immInstr(OP_ST, 3'd4, 3'd0, 9));
        progWords.push_back(immInstr(OP_ST, 3'd5, 3'd0, 10));
        progWords.push_back(immInstr(OP_ST, 3'd6, 3'd0, 11));
        progWords.push_back({OP_HALT, 12'h000});
        loadProgram();
        runUntilHalt();
        r3 = a - 16'd7;
        r4 = r3 + b;
        r5 = r4 - a;
        r6 = r5 & r4;
        r7 = r6 ^ r3;
        hostReadWord(16'd8, got);
        check("ADDI result", got, r3);
        hostReadWord(16'd9, got);
        check("ADD result", got, r4);
        hostReadWord(16'd10, got);
        check("SUB result", got, r5);
        hostReadWord(16'd11, got);
        check("AND result", got, r6);
        hostReadWord(16'd12, got);
        check("XOR result", got, r7);
        finishTest("ALU forwarding");
    endtask

    task automatic loadUseSum();
        wordT c;
        wordT d;
        wordT got;
        restartCore();
        randomWord(c);
        randomWord(d);
        hostWriteWord(1'b0, 16'd2, c);
        hostWriteWord(1'b0, 16'd3, d);
        // Loaded value used at once as rt and then as rs
        progWords.delete();
        progWords.push_back(immInstr(OP_LD, 3'd3, 3'd0, 3));
        progWords.push_back(immInstr(OP_LD, 3'd1, 3'd0, 2));
        progWords.push_back(regInstr(OP_ADD, 3'd2, 3'd3, 3'd1));
        progWords.push_back(immInstr(OP_LD, 3'd4, 3'd0, 2));
        progWords.push_back(regInstr(OP_ADD, 3'd5, 3'd4, 3'd2));
        progWords.push_back(immInstr(OP_ST, 3'd2, 3'd0, 13));
        progWords.push_back(immInstr(OP_ST, 3'd5, 3'd0, 14));
        progWords.push_back({OP_HALT, 12'h000});
        loadProgram();
        runUntilHalt();
        hostReadWord(16'd13, got);
        check("load-use sum on rt", got, d + c);
        hostReadWord(16'd14, got);
        check("load-use sum on rs", got, c + d + c);
        finishTest("load-use stall");
    endtask

    task automatic runBranch(input regIdxT condReg, input logic expectTaken);
        wordT old1;
        wordT old2;
        wordT got;
        restartCore();
        randomWord(old1);
        randomWord(old2);
        old1 = old1 | 16'h0001;
        hostWriteWord(1'b0, 16'd15, old1);
        hostWriteWord(1'b0, 16'd16, old2);
        hostWriteWord(1'b0, 16'd17, ~old1);
        hostWriteWord(1'b0, 16'd18, ~old2);
        progWords.delete();
        progWords.push_back(immInstr(OP_LD, 3'd1, 3'd0, 15));
        progWords.push_back(immInstr(OP_LD, 3'd2, 3'd0, 16));
        progWords.push_back(immInstr(OP_BEQZ, 3'd0, condReg, 2));
        progWords.push_back(immInstr(OP_ADDI, 3'd1, 3'd0, 5));
        progWords.push_back(immInstr(OP_ADDI, 3'd2, 3'd0, 6));
        progWords.push_back(immInstr(OP_ST, 3'd1, 3'd0, 17));
        progWords.push_back(immInstr(OP_ST, 3'd2, 3'd0, 18));
        progWords.push_back({OP_HALT, 12'h000});
        loadProgram();
        runUntilHalt();
        hostReadWord(16'd17, got);
        check("first register after branch", got, expectTaken ? old1 : 16'd5);
        hostReadWord(16'd18, got);
        check("second register after branch", got, expectTaken ? old2 : 16'd6);
    endtask

    task automatic beqzTakenAndNot();
        // r0 stays zero and r1 holds a nonzero word
        runBranch(3'd0, 1'b1);
        runBranch(3'd1, 1'b0);
        finishTest("branches");
    endtask

    task automatic illegalOpcodeStop();
        wordT old;
        wordT got;
        restartCore();
        randomWord(old);
        hostWriteWord(1'b0, 16'd19, ~old);
        hostWriteWord(1'b0, 16'd20, old);
        progWords.delete();
        progWords.push_back(immInstr(OP_ADDI, 3'd1, 3'd0, 9));
        progWords.push_back(immInstr(OP_ST, 3'd1, 3'd0, 19));
        progWords.push_back(16'h8000);
        progWords.push_back(immInstr(OP_ST, 3'd1, 3'd0, 20));
        progWords.push_back({OP_HALT, 12'h000});
        loadProgram();
        runUntilHalt();
        check("err after bad opcode", 16'(err), 16'd1);
        check("halted after bad opcode", 16'(halted), 16'd1);
        hostReadWord(16'd19, got);
        check("store before bad opcode", got, 16'd9);
        hostReadWord(16'd20, got);
        check("store after bad opcode", got, old);
        finishTest("illegal opcode");
    endtask

    task automatic haltHoldsCore();
        wordT w;
        wordT got;
        logic stayed;
        restartCore();
        progWords.delete();
        progWords.push_back(immInstr(OP_ADDI, 3'd1, 3'd0, 7));
        progWords.push_back(immInstr(OP_ST, 3'd1, 3'd0, 22));
        progWords.push_back({OP_HALT, 12'h000});
        loadProgram();
        runUntilHalt();
        // Watch halted for a while with run still high
        stayed = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            stayed = stayed & halted;
        end
        check("halted held", 16'(stayed), 16'd1);
        randomWord(w);
        hostWriteWord(1'b0, 16'd24, w);
        hostReadWord(16'd24, got);
        check("data access while halted", got, w);
        hostReadWord(16'd22, got);
        check("store before halt", got, 16'd7);
        hostWriteWord(1'b0, 16'd23, 16'h0000);
        // New program goes in while halted and runs after reset
        progWords.delete();
        progWords.push_back(immInstr(OP_ADDI, 3'd1, 3'd0, -3));
        progWords.push_back(immInstr(OP_ST, 3'd1, 3'd0, 23));
        progWords.push_back({OP_HALT, 12'h000});
        loadProgram();
        restartCore();
        runUntilHalt();
        hostReadWord(16'd23, got);
        check("program loaded while halted", got, 16'hFFFD);
        finishTest("halt holds the core");
    endtask

    initial begin
        reset      = 1'b1;
        run        = 1'b0;
        hostReq    = 1'b0;
        hostWrite  = 1'b0;
        hostImem   = 1'b0;
        hostAddr   = '0;
        hostWrData = '0;
        lfsrState  = 32'he081;
        checkCount = 0;
        errorCount = 0;
        testErrors = 0;
        resetAndHostAccess();
        aluForwardChain();
        loadUseSum();
        beqzTakenAndNot();
        illegalOpcodeStop();
        haltHoldsCore();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
